/* Bender.yml */
package:
  name: analog_core_emu

sources:
  - files:
      - rtl/acore_const_pkg.sv
      - rtl/chan_func_pkg.sv
      - rtl/chan_func_mem.sv
      - rtl/pi_interp.sv
      - rtl/bit_history.sv
      - rtl/slice_adc.sv
      - rtl/analog_core_emu.sv
  - target: simulation
    files:
      - dv/analog_core_emu_tb.sv

/* analog_core_emu.f */
rtl/acore_const_pkg.sv
rtl/chan_func_pkg.sv
rtl/chan_func_mem.sv
rtl/pi_interp.sv
rtl/bit_history.sv
rtl/slice_adc.sv
rtl/analog_core_emu.sv
dv/analog_core_emu_tb.sv

/* dv/analog_core_emu_tb.sv */
`timescale 1ns/1ns

module analog_core_emu_tb;

    localparam int N_TAP      = 8;
    localparam int ADC_SHIFT  = 6;
    localparam int MAX_REC    = 64;
    localparam int TABLE_SIZE = 512;
    localparam int CHAR_NL    = 10;
    localparam TESTS_FILE     = "dv/analog_core_emu_tests.txt";

    logic        clk;
    logic        rst_n;
    logic [15:0] bits;
    logic [8:0]  ctl_pi_0;
    logic [8:0]  ctl_pi_1;
    logic [8:0]  ctl_pi_2;
    logic [8:0]  ctl_pi_3;
    logic        chan_we;
    logic [8:0]  chan_waddr;
    logic [17:0] chan_wdata_0;
    logic [17:0] chan_wdata_1;
    logic [7:0]  mag_out [16];
    logic [15:0] sign_out;

    // one entry per line of the tests file
    string       rec_kind [MAX_REC];
    string       rec_name [MAX_REC];
    logic [31:0] rec_val  [MAX_REC][20];
    int          rec_count;
    bit          load_ok;

    int cycle_count = 0;
    int cycle_limit = 1000;
    int test_count;
    int pass_count;
    int fail_count;

    analog_core_emu #(
        .N_TAP     (N_TAP),
        .ADC_SHIFT (ADC_SHIFT)
    ) analog_core_emu_inst (
        .clk_i          (clk),
        .rst_n_i        (rst_n),
        .bits_i         (bits),
        .ctl_pi_0_i     (ctl_pi_0),
        .ctl_pi_1_i     (ctl_pi_1),
        .ctl_pi_2_i     (ctl_pi_2),
        .ctl_pi_3_i     (ctl_pi_3),
        .chan_we_i      (chan_we),
        .chan_waddr_i   (chan_waddr),
        .chan_wdata_0_i (chan_wdata_0),
        .chan_wdata_1_i (chan_wdata_1),
        .adder_out_0_o  (mag_out[0]),
        .adder_out_1_o  (mag_out[1]),
        .adder_out_2_o  (mag_out[2]),
        .adder_out_3_o  (mag_out[3]),
        .adder_out_4_o  (mag_out[4]),
        .adder_out_5_o  (mag_out[5]),
        .adder_out_6_o  (mag_out[6]),
        .adder_out_7_o  (mag_out[7]),
        .adder_out_8_o  (mag_out[8]),
        .adder_out_9_o  (mag_out[9]),
        .adder_out_10_o (mag_out[10]),
        .adder_out_11_o (mag_out[11]),
        .adder_out_12_o (mag_out[12]),
        .adder_out_13_o (mag_out[13]),
        .adder_out_14_o (mag_out[14]),
        .adder_out_15_o (mag_out[15]),
        .sign_out_o     (sign_out)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout after %0d cycles, the test sequence did not finish", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    // W has 3 values, P has 4, T has a name and 20 values
    task automatic load_tests();
        int          fd;
        int          n;
        int          ch;
        int          nv;
        bit          done;
        string       tok;
        string       name;
        logic [31:0] v;
        rec_count = 0;
        load_ok   = 1'b1;
        done      = 1'b0;
        fd = $fopen(TESTS_FILE, "r");
        if (fd == 0) begin
            $display("could not open the tests file %s", TESTS_FILE);
            load_ok = 1'b0;
            done    = 1'b1;
        end
        while (!done) begin
            n = $fscanf(fd, "%s", tok);
            if (n != 1) begin
                done = 1'b1;
            end else if (tok[0] == "#") begin
                ch = $fgetc(fd);
                while (ch >= 0 && ch != CHAR_NL) begin
                    ch = $fgetc(fd);
                end
            end else if ((tok == "W" || tok == "P" || tok == "T") && rec_count < MAX_REC) begin
                nv   = (tok == "W") ? 3 : ((tok == "P") ? 4 : 20);
                name = tok;
                if (tok == "T") begin
                    n = $fscanf(fd, "%s", name);
                end
                rec_kind[rec_count] = tok;
                rec_name[rec_count] = name;
                for (int j = 0; j < nv; j++) begin
                    n = $fscanf(fd, "%h", v);
                    if (n != 1) begin
                        $display("record %0d of the tests file is cut short", rec_count);
                        load_ok = 1'b0;
                    end
                    rec_val[rec_count][j] = v;
                end
                rec_count++;
            end else begin
                $display("unexpected record %s in the tests file", tok);
                load_ok = 1'b0;
                done    = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    task automatic report_test(input string name, input int errs);
        test_count++;
        if (errs == 0) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: fail, %0d mismatches", name, errs);
        end
    endtask

    task automatic check_reset();
        int errs;
        errs = 0;
        if (sign_out !== 16'h0000) begin
            $display("error: reset sign_out_o got 0x%04h expected 0x0000", sign_out);
            errs++;
        end
        for (int i = 0; i < 16; i++) begin
            if (mag_out[i] !== 8'h00) begin
                $display("error: reset adder_out_%0d_o got 0x%02h expected 0x00", i, mag_out[i]);
                errs++;
            end
        end
        report_test("reset", errs);
    endtask

    // phase 0 entries first, those are read right after reset
    task automatic clear_table();
        for (int p = 0; p < TABLE_SIZE / N_TAP; p++) begin
            for (int k = 0; k < N_TAP; k++) begin
                @(posedge clk);
                chan_we      <= 1'b1;
                chan_waddr   <= 9'(k * 64 + p);
                chan_wdata_0 <= '0;
                chan_wdata_1 <= '0;
            end
        end
        @(posedge clk);
        chan_we <= 1'b0;
    endtask

    task automatic apply_write(input int r);
        @(posedge clk);
        chan_we      <= 1'b1;
        chan_waddr   <= rec_val[r][0][8:0];
        chan_wdata_0 <= rec_val[r][1][17:0];
        chan_wdata_1 <= rec_val[r][2][17:0];
    endtask

    task automatic apply_codes(input int r);
        @(posedge clk);
        chan_we  <= 1'b0;
        ctl_pi_0 <= rec_val[r][0][8:0];
        ctl_pi_1 <= rec_val[r][1][8:0];
        ctl_pi_2 <= rec_val[r][2][8:0];
        ctl_pi_3 <= rec_val[r][3][8:0];
    endtask

    task automatic run_test(input int r);
        int         errs;
        logic [7:0] exp_mag;
        errs = 0;
        for (int w = 0; w < 3; w++) begin
            @(posedge clk);
            chan_we <= 1'b0;
            bits    <= rec_val[r][w][15:0];
        end
        // last word shows up on the third edge after it is driven
        repeat (3) @(posedge clk);
        @(negedge clk);
        if (sign_out !== rec_val[r][3][15:0]) begin
            $display("error: %s sign_out_o got 0x%04h expected 0x%04h",
                     rec_name[r], sign_out, rec_val[r][3][15:0]);
            errs++;
        end
        for (int i = 0; i < 16; i++) begin
            exp_mag = rec_val[r][4 + i][7:0];
            if (mag_out[i] !== exp_mag) begin
                $display("error: %s adder_out_%0d_o got 0x%02h expected 0x%02h",
                         rec_name[r], i, mag_out[i], exp_mag);
                errs++;
            end
        end
        report_test(rec_name[r], errs);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        bits         = '0;
        ctl_pi_0     = '0;
        ctl_pi_1     = '0;
        ctl_pi_2     = '0;
        ctl_pi_3     = '0;
        chan_we      = 1'b0;
        chan_waddr   = '0;
        chan_wdata_0 = '0;
        chan_wdata_1 = '0;
        test_count   = 0;
        pass_count   = 0;
        fail_count   = 0;
        load_tests();
        cycle_limit = 4 + TABLE_SIZE + rec_count * 8 + 100;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_reset();
        clear_table();

        for (int r = 0; r < rec_count; r++) begin
            if (rec_kind[r] == "W") begin
                apply_write(r);
            end else if (rec_kind[r] == "P") begin
                apply_codes(r);
            end else begin
                run_test(r);
            end
        end

        $display("tests run %0d, passed %0d, failed %0d", test_count, pass_count, fail_count);
        if (load_ok && rec_count > 0 && fail_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* dv/analog_core_emu_tests.txt */
# W addr data_0 data_1 | P pi_0 pi_1 pi_2 pi_3 | values in hex
# T name word_0 word_1 word_2 sign mag_0 .. mag_15 | sign and mags are the outputs for word_2
P 000 000 000 000
W 000 00c80 00000
T cursor 0000 ffff a5c3 a5c3 32 32 32 32 32 32 32 32 32 32 32 32 32 32 32 32
W 040 00640 00000
T isi_prev1 0000 8000 0001 0001 4b 19 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b
T isi_prev0 0000 0000 0001 0001 19 19 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b 4b
W 001 00c80 00400
W 002 01000 3fcdf
W 003 00800 00100
W 043 3fe00 00040
P 000 00c 013 01f
T interp 0000 0000 ffff ffff 19 4b 4b 4b 3a 3a 3a 3a 3b 3b 3b 3b 1c 1c 1c 1c
P 000 000 000 000
W 000 1ffff 00000
T sat_pos 0000 1234 c3a5 c3a5 ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
W 000 20000 00000
T sat_neg 0000 1234 c3a5 3c5a ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff ff
W 000 00c80 00000
W 040 3fce0 00000
T rewrite 0000 ffff 00ff 00ff 25 25 25 25 25 25 25 25 3e 25 25 25 25 25 25 25

/* rtl/acore_const_pkg.sv */
package acore_const_pkg;

    // number of time-interleaved slices, also the width of one bit word
    localparam int NTI = 16;

    // phase interpolator groups, slice i sits in group i / (NTI / NOUT)
    localparam int NOUT = 4;

    // PI code width
    // upper bits pick the phase index, lower bits the interpolation fraction
    localparam int NPI = 9;

    // fraction field at the bottom of the PI code
    localparam int PI_FRAC_W = 3;

    // ADC magnitude width per slice
    localparam int NADC = 8;

endpackage

/* rtl/analog_core_emu.sv */
`timescale 1ns/1ns

module analog_core_emu #(
    parameter int N_TAP     = 8,
    parameter int ADC_SHIFT = 6
) (
    input  logic                                          clk_i,
    input  logic                                          rst_n_i,

    // transmitted bits, one word per cycle
    input  logic        [acore_const_pkg::NTI-1:0]           bits_i,

    // PI codes, one per group of slices
    input  logic        [acore_const_pkg::NPI-1:0]           ctl_pi_0_i,
    input  logic        [acore_const_pkg::NPI-1:0]           ctl_pi_1_i,
    input  logic        [acore_const_pkg::NPI-1:0]           ctl_pi_2_i,
    input  logic        [acore_const_pkg::NPI-1:0]           ctl_pi_3_i,

    // pulse-response table load
    input  logic                                          chan_we_i,
    input  logic        [chan_func_pkg::FUNC_ADDR_W-1:0]     chan_waddr_i,
    input  logic signed [chan_func_pkg::FUNC_DATA_WIDTH-1:0] chan_wdata_0_i,
    input  logic signed [chan_func_pkg::FUNC_DATA_WIDTH-1:0] chan_wdata_1_i,

    // ADC magnitudes
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_0_o,
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_1_o,
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_2_o,
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_3_o,
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_4_o,
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_5_o,
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_6_o,
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_7_o,
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_8_o,
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_9_o,
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_10_o,
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_11_o,
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_12_o,
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_13_o,
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_14_o,
    output logic        [acore_const_pkg::NADC-1:0]          adder_out_15_o,

    // ADC signs
    output logic        [acore_const_pkg::NTI-1:0]           sign_out_o
);
    import acore_const_pkg::*;
    import chan_func_pkg::*;

    localparam int GRP_SIZE = NTI / NOUT;

    logic        [NPI-1:0]             ctl_pi  [NOUT];
    logic        [FUNC_ADDR_W-1:0]     raddr   [NOUT][N_TAP];
    logic signed [FUNC_DATA_WIDTH-1:0] rdata_0 [NOUT][N_TAP];
    logic signed [FUNC_DATA_WIDTH-1:0] rdata_1 [NOUT][N_TAP];
    logic signed [FUNC_DATA_WIDTH-1:0] sample  [NOUT][N_TAP];
    logic        [NTI+N_TAP-2:0]       hist;
    logic        [NADC-1:0]            adder_out [NTI];

    assign ctl_pi[0] = ctl_pi_0_i;
    assign ctl_pi[1] = ctl_pi_1_i;
    assign ctl_pi[2] = ctl_pi_2_i;
    assign ctl_pi[3] = ctl_pi_3_i;

    chan_func_mem #(
        .N_TAP(N_TAP)
    ) chan_func_mem_inst (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .we_i      (chan_we_i),
        .waddr_i   (chan_waddr_i),
        .wdata_0_i (chan_wdata_0_i),
        .wdata_1_i (chan_wdata_1_i),
        .raddr_i   (raddr),
        .rdata_0_o (rdata_0),
        .rdata_1_o (rdata_1)
    );

    for (genvar g = 0; g < NOUT; g++) begin : g_grp
        pi_interp #(
            .N_TAP(N_TAP)
        ) pi_interp_inst (
            .clk_i     (clk_i),
            .rst_n_i   (rst_n_i),
            .ctl_pi_i  (ctl_pi[g]),
            .raddr_o   (raddr[g]),
            .rdata_0_i (rdata_0[g]),
            .rdata_1_i (rdata_1[g]),
            .sample_o  (sample[g])
        );
    end

    bit_history #(
        .N_TAP(N_TAP)
    ) bit_history_inst (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .bits_i  (bits_i),
        .hist_o  (hist)
    );

    // each slice takes its group's samples
    for (genvar i = 0; i < NTI; i++) begin : g_slice
        slice_adc #(
            .N_TAP     (N_TAP),
            .ADC_SHIFT (ADC_SHIFT)
        ) slice_adc_inst (
            .clk_i    (clk_i),
            .rst_n_i  (rst_n_i),
            .bits_i   (hist[i +: N_TAP]),
            .sample_i (sample[i / GRP_SIZE]),
            .mag_o    (adder_out[i]),
            .sign_o   (sign_out_o[i])
        );
    end

    assign adder_out_0_o  = adder_out[0];
    assign adder_out_1_o  = adder_out[1];
    assign adder_out_2_o  = adder_out[2];
    assign adder_out_3_o  = adder_out[3];
    assign adder_out_4_o  = adder_out[4];
    assign adder_out_5_o  = adder_out[5];
    assign adder_out_6_o  = adder_out[6];
    assign adder_out_7_o  = adder_out[7];
    assign adder_out_8_o  = adder_out[8];
    assign adder_out_9_o  = adder_out[9];
    assign adder_out_10_o = adder_out[10];
    assign adder_out_11_o = adder_out[11];
    assign adder_out_12_o = adder_out[12];
    assign adder_out_13_o = adder_out[13];
    assign adder_out_14_o = adder_out[14];
    assign adder_out_15_o = adder_out[15];

endmodule

/* rtl/bit_history.sv */
`timescale 1ns/1ns

module bit_history #(
    parameter int N_TAP = 8
) (
    input  logic                                    clk_i,
    input  logic                                    rst_n_i,
    input  logic [acore_const_pkg::NTI-1:0]         bits_i,
    output logic [acore_const_pkg::NTI+N_TAP-2:0]   hist_o
);
    import acore_const_pkg::*;

    // current word on top, tail of the previous word below it
    localparam int HIST_W = NTI + N_TAP - 1;

    logic [NTI-1:0]    word_q;
    logic [HIST_W-1:0] hist_q;

    // second stage reuses the top bits it already holds as the older tail
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            word_q <= '0;
            hist_q <= '0;
        end else begin
            word_q <= bits_i;
            hist_q <= {word_q, hist_q[HIST_W-1 -: N_TAP-1]};
        end
    end

    // slice i reads hist_o[i +: N_TAP], its own bit at the top
    assign hist_o = hist_q;

endmodule

/* rtl/chan_func_mem.sv */
`timescale 1ns/1ns

module chan_func_mem #(
    parameter int N_TAP = 8
) (
    input  logic                                          clk_i,
    input  logic                                          rst_n_i,

    // table write port
    input  logic                                          we_i,
    input  logic        [chan_func_pkg::FUNC_ADDR_W-1:0]     waddr_i,
    input  logic signed [chan_func_pkg::FUNC_DATA_WIDTH-1:0] wdata_0_i,
    input  logic signed [chan_func_pkg::FUNC_DATA_WIDTH-1:0] wdata_1_i,

    // one read port per group and tap
    input  logic        [chan_func_pkg::FUNC_ADDR_W-1:0]
                        raddr_i [acore_const_pkg::NOUT][N_TAP],
    output logic signed [chan_func_pkg::FUNC_DATA_WIDTH-1:0]
                        rdata_0_o [acore_const_pkg::NOUT][N_TAP],
    output logic signed [chan_func_pkg::FUNC_DATA_WIDTH-1:0]
                        rdata_1_o [acore_const_pkg::NOUT][N_TAP]
);
    import acore_const_pkg::*;
    import chan_func_pkg::*;

    // bank 0 holds the pulse sample, bank 1 the slope to the next phase
    logic signed [FUNC_DATA_WIDTH-1:0] bank_0 [FUNC_DEPTH];
    logic signed [FUNC_DATA_WIDTH-1:0] bank_1 [FUNC_DEPTH];

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            bank_0[waddr_i] <= wdata_0_i;
            bank_1[waddr_i] <= wdata_1_i;
        end
    end

    // registered reads, old data on a same-cycle write
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int g = 0; g < NOUT; g++) begin
                for (int k = 0; k < N_TAP; k++) begin
                    rdata_0_o[g][k] <= '0;
                    rdata_1_o[g][k] <= '0;
                end
            end
        end else begin
            for (int g = 0; g < NOUT; g++) begin
                for (int k = 0; k < N_TAP; k++) begin
                    rdata_0_o[g][k] <= bank_0[raddr_i[g][k]];
                    rdata_1_o[g][k] <= bank_1[raddr_i[g][k]];
                end
            end
        end
    end

    // a write to an unknown address would corrupt the whole table
    a_waddr_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        we_i |-> !$isunknown(waddr_i))
        else $error("chan_func_mem: unknown write address with we_i high");

endmodule

/* rtl/chan_func_pkg.sv */
package chan_func_pkg;

    // signed pulse-response word
    localparam int FUNC_DATA_WIDTH = 18;

    // table address is {tap index, phase index}
    localparam int FUNC_ADDR_W = 9;

    // phase index in the low part of the address
    localparam int FUNC_PHASE_W = 6;

    // entries per bank
    localparam int FUNC_DEPTH = 512;

endpackage

/* rtl/pi_interp.sv */
`timescale 1ns/1ns

module pi_interp #(
    parameter int N_TAP = 8
) (
    input  logic                                          clk_i,
    input  logic                                          rst_n_i,
    input  logic        [acore_const_pkg::NPI-1:0]           ctl_pi_i,

    // table read side
    output logic        [chan_func_pkg::FUNC_ADDR_W-1:0]     raddr_o [N_TAP],
    input  logic signed [chan_func_pkg::FUNC_DATA_WIDTH-1:0] rdata_0_i [N_TAP],
    input  logic signed [chan_func_pkg::FUNC_DATA_WIDTH-1:0] rdata_1_i [N_TAP],

    // interpolated pulse sample per tap
    output logic signed [chan_func_pkg::FUNC_DATA_WIDTH-1:0] sample_o [N_TAP]
);
    import acore_const_pkg::*;
    import chan_func_pkg::*;

    localparam int TAP_W  = FUNC_ADDR_W - FUNC_PHASE_W;
    localparam int PROD_W = FUNC_DATA_WIDTH + PI_FRAC_W + 1;

    logic [NPI-1:0]          code_q;
    logic [PI_FRAC_W-1:0]    frac_q;
    logic [FUNC_PHASE_W-1:0] phase;

    // fraction follows the code by one cycle so it meets the read data
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            code_q <= '0;
            frac_q <= '0;
        end else begin
            code_q <= ctl_pi_i;
            frac_q <= code_q[PI_FRAC_W-1:0];
        end
    end

    assign phase = code_q[NPI-1:PI_FRAC_W];

    for (genvar k = 0; k < N_TAP; k++) begin : g_tap
        logic signed [PROD_W-1:0] prod;
        logic signed [PROD_W-1:0] interp;

        assign raddr_o[k] = {TAP_W'(k), phase};

        // sample + slope * frac / 8
        assign prod   = rdata_1_i[k] * $signed({1'b0, frac_q});
        assign interp = rdata_0_i[k] + (prod >>> PI_FRAC_W);

        always_ff @(posedge clk_i) begin
            if (!rst_n_i) begin
                sample_o[k] <= '0;
            end else begin
                sample_o[k] <= interp[FUNC_DATA_WIDTH-1:0];
            end
        end
    end

endmodule

/* rtl/slice_adc.sv */
`timescale 1ns/1ns

module slice_adc #(
    parameter int N_TAP     = 8,
    parameter int ADC_SHIFT = 6
) (
    input  logic                                          clk_i,
    input  logic                                          rst_n_i,

    // bits_i[N_TAP-1] is this slice's bit and lower bits are older
    input  logic        [N_TAP-1:0]                          bits_i,
    input  logic signed [chan_func_pkg::FUNC_DATA_WIDTH-1:0] sample_i [N_TAP],

    output logic        [acore_const_pkg::NADC-1:0]          mag_o,
    output logic                                          sign_o
);
    import acore_const_pkg::*;
    import chan_func_pkg::*;

    // headroom for N_TAP signed terms
    localparam int SUM_W = FUNC_DATA_WIDTH + $clog2(N_TAP) + 1;
    localparam logic [SUM_W-1:0] MAG_MAX = SUM_W'((1 << NADC) - 1);

    logic signed [SUM_W-1:0] sum;
    logic        [SUM_W-1:0] abs_sum;
    logic        [SUM_W-1:0] shifted;
    logic        [SUM_W-1:0] mag_sat;

    // tap k pairs with the bit k positions back and a 0 counts as -1
    always_comb begin
        sum = '0;
        for (int k = 0; k < N_TAP; k++) begin
            if (bits_i[N_TAP-1-k]) begin
                sum = sum + SUM_W'(sample_i[k]);
            end else begin
                sum = sum - SUM_W'(sample_i[k]);
            end
        end
    end

    always_comb begin
        abs_sum = sum[SUM_W-1] ? SUM_W'(-sum) : SUM_W'(sum);
        shifted = abs_sum >> ADC_SHIFT;
        mag_sat = (shifted > MAG_MAX) ? MAG_MAX : shifted;
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mag_o  <= '0;
            sign_o <= 1'b0;
        end else begin
            mag_o  <= mag_sat[NADC-1:0];
            // zero counts as positive
            sign_o <= ~sum[SUM_W-1];
        end
    end

    // registered magnitude picks the ADC step that holds the previous sum
    // full scale only needs the lower bound
    a_mag_matches_sum: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !$isunknown(abs_sum) |=>
            ((SUM_W'(mag_o) << ADC_SHIFT) <= $past(abs_sum)) &&
            ((mag_o == NADC'(MAG_MAX)) ||
             ($past(abs_sum) < ((SUM_W'(mag_o) + 1) << ADC_SHIFT))))
        else $error("slice_adc: magnitude 0x%0h does not match the sum", mag_o);

endmodule
